/* logic/lrq_pkg.sv */
`default_nettype none

package lrq_pkg;

  // ----------------------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------------------
  localparam int LRQ_ENTRIES = 8;
  localparam int LRQ_IDX_W   = $clog2(LRQ_ENTRIES);
  localparam int PADDR_W     = 32;
  localparam int LINE_OFF_W  = 6;
  localparam int LINE_W      = PADDR_W - LINE_OFF_W;

  // Tag is source bit, filler bit, entry index
  localparam int       L2_TAG_W   = 5;
  localparam logic     L2_SRC_L1D = 1'b1;
  localparam logic [1:0] L2_CMD_RD = 2'b00;

  // ----------------------------------------------------------------------
  // Requester side
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic               valid;
    logic [PADDR_W-1:0] paddr;
  } lrq_req_t;

  typedef struct packed {
    logic                   full;
    logic                   conflict;
    logic [LRQ_ENTRIES-1:0] index_oh;
  } lrq_resp_t;

  typedef struct packed {
    logic              valid;
    logic              sent;
    logic [LINE_W-1:0] line;
  } lrq_entry_t;

  // ----------------------------------------------------------------------
  // L2 side and load queue report
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic                valid;
    logic [1:0]          cmd;
    logic [PADDR_W-1:0]  addr;
    logic [L2_TAG_W-1:0] tag;
  } l2_req_t;

  typedef struct packed {
    logic                valid;
    logic [L2_TAG_W-1:0] tag;
  } l2_resp_t;

  typedef struct packed {
    logic                   valid;
    logic [LRQ_ENTRIES-1:0] resolve_index_oh;
  } lrq_resolve_t;

endpackage

`default_nettype wire

/* logic/lrq_entry.sv */
`default_nettype none

module lrq_entry (
  input  wire                 i_clk,
  input  wire                 i_reset_n,

  input  wire                 i_load,
  input  lrq_pkg::lrq_entry_t i_load_entry,

  input  wire                 i_sent,
  input  wire                 i_free,

  output lrq_pkg::lrq_entry_t o_entry
);

  import lrq_pkg::*;

  logic              r_valid;
  logic              r_sent;
  logic [LINE_W-1:0] r_line;

  // Allocation only targets free entries, so load never meets sent or free
  always_ff @(posedge i_clk, posedge i_reset_n) begin
    if (i_reset_n) begin
      r_valid <= 1'b0;
      r_sent  <= 1'b0;
    end else if (i_load) begin
      r_valid <= i_load_entry.valid;
      r_sent  <= i_load_entry.sent;
    end else if (i_free) begin
      r_valid <= 1'b0;
      r_sent  <= 1'b0;
    end else if (i_sent) begin
      r_sent  <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_load) begin
      r_line <= i_load_entry.line;
    end
  end

  always_comb begin
    o_entry       = '0;
    o_entry.valid = r_valid;
    o_entry.sent  = r_sent;
    o_entry.line  = r_line;
  end

endmodule

`default_nettype wire

/* logic/lrq_alloc.sv */
`default_nettype none

module lrq_alloc #(
  parameter int N_LOAD_PORTS = 2
) (
  input  lrq_pkg::lrq_req_t  [N_LOAD_PORTS-1:0]         i_load_req,
  input  lrq_pkg::lrq_req_t                             i_stq_req,

  input  lrq_pkg::lrq_entry_t [lrq_pkg::LRQ_ENTRIES-1:0] i_entries,

  output lrq_pkg::lrq_resp_t [N_LOAD_PORTS-1:0]         o_load_resp,
  output lrq_pkg::lrq_resp_t                            o_stq_resp,

  output logic [lrq_pkg::LRQ_ENTRIES-1:0]               o_entry_load,
  output lrq_pkg::lrq_entry_t [lrq_pkg::LRQ_ENTRIES-1:0] o_new_entry
);

  import lrq_pkg::*;

  // Requester order: load ports first, store-miss port last
  localparam int N_REQ = N_LOAD_PORTS + 1;

  lrq_req_t  [N_REQ-1:0]                   w_req;
  logic      [N_REQ-1:0][LINE_W-1:0]       w_req_line;
  logic      [LRQ_ENTRIES-1:0]             w_entry_vld;
  logic      [N_REQ-1:0][LRQ_ENTRIES-1:0]  w_hit_entry;
  logic      [N_REQ-1:0]                   w_hit_port;
  logic      [N_REQ-1:0]                   w_conflict;
  logic      [N_REQ-1:0][LRQ_ENTRIES-1:0]  w_grant_oh;
  logic      [N_REQ-1:0]                   w_full;
  lrq_resp_t [N_REQ-1:0]                   w_resp;

  assign w_req = {i_stq_req, i_load_req};

  always_comb begin
    for (int r = 0; r < N_REQ; r++) begin
      w_req_line[r] = w_req[r].paddr[PADDR_W-1:LINE_OFF_W];
    end
    for (int e = 0; e < LRQ_ENTRIES; e++) begin
      w_entry_vld[e] = i_entries[e].valid;
    end
  end

  // ----------------------------------------------------------------------
  // Same-line detection
  // ----------------------------------------------------------------------

  // Against lines already held in the queue
  always_comb begin
    for (int r = 0; r < N_REQ; r++) begin
      for (int e = 0; e < LRQ_ENTRIES; e++) begin
        w_hit_entry[r][e] = w_req[r].valid & i_entries[e].valid &
                            (i_entries[e].line == w_req_line[r]);
      end
    end
  end

  // Against earlier requesters in the same cycle
  always_comb begin
    for (int r = 0; r < N_REQ; r++) begin
      w_hit_port[r] = 1'b0;
      for (int q = 0; q < r; q++) begin
        if (w_req[q].valid && w_req[r].valid && (w_req_line[q] == w_req_line[r])) begin
          w_hit_port[r] = 1'b1;
        end
      end
    end
  end

  assign w_conflict = w_hit_port | reduce_hits(w_hit_entry);

  function automatic logic [N_REQ-1:0] reduce_hits(
    input logic [N_REQ-1:0][LRQ_ENTRIES-1:0] hits
  );
    logic [N_REQ-1:0] any;
    for (int r = 0; r < N_REQ; r++) begin
      any[r] = |hits[r];
    end
    return any;
  endfunction

  // ----------------------------------------------------------------------
  // Lowest-free allocation, walked in requester order
  // ----------------------------------------------------------------------
  always_comb begin
    logic [LRQ_ENTRIES-1:0] free_mask;
    free_mask = ~w_entry_vld;
    for (int r = 0; r < N_REQ; r++) begin
      w_grant_oh[r] = '0;
      w_full[r]     = 1'b0;
      if (w_req[r].valid && !w_conflict[r]) begin
        if (free_mask == '0) begin
          // Dropped, requester retries
          w_full[r] = 1'b1;
        end else begin
          w_grant_oh[r] = free_mask & (~free_mask + 1'b1);
          free_mask     = free_mask & ~w_grant_oh[r];
        end
      end
    end
  end

  // Payload of the requester that claimed each entry
  always_comb begin
    for (int e = 0; e < LRQ_ENTRIES; e++) begin
      o_entry_load[e] = 1'b0;
      o_new_entry[e]  = '0;
      for (int r = 0; r < N_REQ; r++) begin
        if (w_grant_oh[r][e]) begin
          o_entry_load[e]     = 1'b1;
          o_new_entry[e].line = w_req_line[r];
        end
      end
      o_new_entry[e].valid = o_entry_load[e];
      o_new_entry[e].sent  = 1'b0;
    end
  end

  // ----------------------------------------------------------------------
  // Responses
  // ----------------------------------------------------------------------

  // index_oh stays zero when the match is only with another port
  always_comb begin
    for (int r = 0; r < N_REQ; r++) begin
      w_resp[r].full     = w_full[r];
      w_resp[r].conflict = w_conflict[r];
      w_resp[r].index_oh = w_hit_entry[r];
    end
  end

  assign o_load_resp = w_resp[N_LOAD_PORTS-1:0];
  assign o_stq_resp  = w_resp[N_LOAD_PORTS];

endmodule

`default_nettype wire

/* logic/lrq_l2_issue.sv */
`default_nettype none

module lrq_l2_issue (
  input  wire                                             i_clk,
  input  wire                                             i_reset_n,

  input  lrq_pkg::lrq_entry_t [lrq_pkg::LRQ_ENTRIES-1:0]  i_entries,

  output lrq_pkg::l2_req_t                                o_l2_req,
  input  wire                                             i_l2_req_ready,

  input  lrq_pkg::l2_resp_t                               i_l2_resp,

  output logic [lrq_pkg::LRQ_ENTRIES-1:0]                 o_entry_sent,
  output logic [lrq_pkg::LRQ_ENTRIES-1:0]                 o_entry_free,

  output lrq_pkg::lrq_resolve_t                           o_lrq_resolve
);

  import lrq_pkg::*;

  localparam int TAG_FILL_W = L2_TAG_W - 1 - LRQ_IDX_W;

  logic                 w_pick_vld;
  logic [LRQ_IDX_W-1:0] w_pick_idx;
  logic [LRQ_IDX_W-1:0] w_sel_idx;
  logic                 w_req_vld;
  logic                 w_handshake;
  logic                 r_hold;
  logic [LRQ_IDX_W-1:0] r_hold_idx;
  logic                 w_resp_hit;
  logic [LRQ_IDX_W-1:0] w_resp_idx;

  // ----------------------------------------------------------------------
  // Request side
  // ----------------------------------------------------------------------

  // Lowest valid entry not yet sent
  always_comb begin
    w_pick_vld = 1'b0;
    w_pick_idx = '0;
    for (int e = LRQ_ENTRIES - 1; e >= 0; e--) begin
      if (i_entries[e].valid && !i_entries[e].sent) begin
        w_pick_vld = 1'b1;
        w_pick_idx = LRQ_IDX_W'(e);
      end
    end
  end

  // A stalled command keeps its entry even if a lower one gets loaded
  assign w_sel_idx   = r_hold ? r_hold_idx : w_pick_idx;
  assign w_req_vld   = r_hold | w_pick_vld;
  assign w_handshake = w_req_vld & i_l2_req_ready;

  always_ff @(posedge i_clk, posedge i_reset_n) begin
    if (i_reset_n) begin
      r_hold <= 1'b0;
    end else begin
      r_hold <= w_req_vld & ~i_l2_req_ready;
    end
  end

  always_ff @(posedge i_clk) begin
    r_hold_idx <= w_sel_idx;
  end

  always_comb begin
    o_l2_req       = '0;
    o_l2_req.valid = w_req_vld;
    o_l2_req.cmd   = L2_CMD_RD;
    o_l2_req.addr  = {i_entries[w_sel_idx].line, {LINE_OFF_W{1'b0}}};
    o_l2_req.tag   = {L2_SRC_L1D, {TAG_FILL_W{1'b0}}, w_sel_idx};
  end

  assign o_entry_sent = w_handshake ? (LRQ_ENTRIES'(1) << w_sel_idx) : '0;

  // ----------------------------------------------------------------------
  // Fill response and resolve
  // ----------------------------------------------------------------------
  assign w_resp_hit   = i_l2_resp.valid & (i_l2_resp.tag[L2_TAG_W-1] == L2_SRC_L1D);
  assign w_resp_idx   = i_l2_resp.tag[LRQ_IDX_W-1:0];
  assign o_entry_free = w_resp_hit ? (LRQ_ENTRIES'(1) << w_resp_idx) : '0;

  always_ff @(posedge i_clk, posedge i_reset_n) begin
    if (i_reset_n) begin
      o_lrq_resolve <= '0;
    end else begin
      o_lrq_resolve.valid            <= w_resp_hit;
      o_lrq_resolve.resolve_index_oh <= o_entry_free;
    end
  end

endmodule

`default_nettype wire

/* logic/l1d_load_requester.sv */
`default_nettype none

module l1d_load_requester #(
  parameter int N_LOAD_PORTS = 2
) (
  input  wire                                     i_clk,
  input  wire                                     i_reset_n,

  // Load pipeline miss ports
  input  lrq_pkg::lrq_req_t  [N_LOAD_PORTS-1:0]   i_load_req,
  output lrq_pkg::lrq_resp_t [N_LOAD_PORTS-1:0]   o_load_resp,

  // Store queue miss port
  input  lrq_pkg::lrq_req_t                       i_stq_req,
  output lrq_pkg::lrq_resp_t                      o_stq_resp,

  output lrq_pkg::l2_req_t                        o_l2_req,
  input  wire                                     i_l2_req_ready,
  input  lrq_pkg::l2_resp_t                       i_l2_resp,

  output lrq_pkg::lrq_resolve_t                   o_lrq_resolve
);

  import lrq_pkg::*;

  lrq_entry_t [LRQ_ENTRIES-1:0] w_entries;
  lrq_entry_t [LRQ_ENTRIES-1:0] w_new_entry;
  logic       [LRQ_ENTRIES-1:0] w_entry_load;
  logic       [LRQ_ENTRIES-1:0] w_entry_sent;
  logic       [LRQ_ENTRIES-1:0] w_entry_free;

  lrq_alloc #(
    .N_LOAD_PORTS (N_LOAD_PORTS)
  ) u_alloc (
    .i_load_req   (i_load_req),
    .i_stq_req    (i_stq_req),
    .i_entries    (w_entries),
    .o_load_resp  (o_load_resp),
    .o_stq_resp   (o_stq_resp),
    .o_entry_load (w_entry_load),
    .o_new_entry  (w_new_entry)
  );

  // ----------------------------------------------------------------------
  // Entry array
  // ----------------------------------------------------------------------
  for (genvar e = 0; e < LRQ_ENTRIES; e++) begin : g_entry
    lrq_entry u_entry (
      .i_clk        (i_clk),
      .i_reset_n    (i_reset_n),
      .i_load       (w_entry_load[e]),
      .i_load_entry (w_new_entry[e]),
      .i_sent       (w_entry_sent[e]),
      .i_free       (w_entry_free[e]),
      .o_entry      (w_entries[e])
    );
  end

  lrq_l2_issue u_l2_issue (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_entries      (w_entries),
    .o_l2_req       (o_l2_req),
    .i_l2_req_ready (i_l2_req_ready),
    .i_l2_resp      (i_l2_resp),
    .o_entry_sent   (w_entry_sent),
    .o_entry_free   (w_entry_free),
    .o_lrq_resolve  (o_lrq_resolve)
  );

endmodule

`default_nettype wire

/* tb/l1d_load_requester_chk.sv */
`default_nettype none

module l1d_load_requester_chk #(
  parameter int N_LOAD_PORTS = 2
) (
  input  wire                                    i_clk,
  input  wire                                    i_reset_n,
  input  lrq_pkg::lrq_resp_t [N_LOAD_PORTS-1:0]  i_load_resp,
  input  lrq_pkg::lrq_resp_t                     i_stq_resp,
  input  lrq_pkg::l2_req_t                       i_l2_req,
  input  wire                                    i_l2_req_ready,
  input  lrq_pkg::l2_resp_t                      i_l2_resp,
  input  lrq_pkg::lrq_resolve_t                  i_lrq_resolve
);

  import lrq_pkg::*;

  int   n_fail = 0;
  logic w_resp_l1d;

  assign w_resp_l1d = i_l2_resp.valid && (i_l2_resp.tag[L2_TAG_W-1] == L2_SRC_L1D);

  // Quiet outputs through reset and the first cycle after it
  a_reset_quiet: assert property (@(posedge i_clk)
    (i_reset_n || $past(i_reset_n)) |-> (!i_l2_req.valid && !i_lrq_resolve.valid))
    else begin
      $error("L2 request or resolve valid high around reset");
      n_fail++;
    end

  for (genvar p = 0; p < N_LOAD_PORTS; p++) begin : g_port
    a_load_onehot: assert property (@(posedge i_clk) disable iff (i_reset_n)
      $onehot0(i_load_resp[p].index_oh))
      else begin
        $error("Load port index_oh marks more than one entry");
        n_fail++;
      end
  end

  a_stq_onehot: assert property (@(posedge i_clk) disable iff (i_reset_n)
    $onehot0(i_stq_resp.index_oh))
    else begin
      $error("Store-miss index_oh marks more than one entry");
      n_fail++;
    end

  // A stalled L2 command holds its payload
  a_l2_stable: assert property (@(posedge i_clk) disable iff (i_reset_n)
    (i_l2_req.valid && !i_l2_req_ready) |=> (i_l2_req.valid && $stable(i_l2_req)))
    else begin
      $error("L2 request dropped or changed while stalled");
      n_fail++;
    end

  a_resolve_after: assert property (@(posedge i_clk) disable iff (i_reset_n)
    w_resp_l1d |=> i_lrq_resolve.valid)
    else begin
      $error("No resolve one cycle after an L1D fill response");
      n_fail++;
    end

  a_resolve_only: assert property (@(posedge i_clk) disable iff (i_reset_n)
    !w_resp_l1d |=> !i_lrq_resolve.valid)
    else begin
      $error("Resolve without an L1D fill response");
      n_fail++;
    end

endmodule

bind l1d_load_requester l1d_load_requester_chk #(
  .N_LOAD_PORTS (N_LOAD_PORTS)
) u_chk (
  .i_clk          (i_clk),
  .i_reset_n      (i_reset_n),
  .i_load_resp    (o_load_resp),
  .i_stq_resp     (o_stq_resp),
  .i_l2_req       (o_l2_req),
  .i_l2_req_ready (i_l2_req_ready),
  .i_l2_resp      (i_l2_resp),
  .i_lrq_resolve  (o_lrq_resolve)
);

`default_nettype wire

/* tb/tb_l1d_load_requester.sv */
`default_nettype none

module tb_l1d_load_requester;

  import lrq_pkg::*;

  localparam int N_LOAD_PORTS = 2;
  localparam int N_REQ        = N_LOAD_PORTS + 1;
  localparam int STIM_CYCLES  = 2000;
  localparam int DRAIN_CYCLES = 1000;
  localparam int CYCLE_LIMIT  = STIM_CYCLES + DRAIN_CYCLES;

  logic                         clk;
  logic                         reset_n;
  lrq_req_t  [N_LOAD_PORTS-1:0] load_req;
  lrq_resp_t [N_LOAD_PORTS-1:0] load_resp;
  lrq_req_t                     stq_req;
  lrq_resp_t                    stq_resp;
  l2_req_t                      l2_req;
  logic                         l2_ready;
  l2_resp_t                     l2_resp;
  lrq_resolve_t                 resolve;

  // Reference queue and L2 model
  logic [LRQ_ENTRIES-1:0] m_valid;
  logic [LRQ_ENTRIES-1:0] m_sent;
  logic [LINE_W-1:0]      m_line [LRQ_ENTRIES];
  logic                   m_hold;
  int                     m_hold_idx;
  lrq_resolve_t           m_resolve;
  logic [L2_TAG_W-1:0]    pend_tag [$];
  int                     pend_due [$];
  logic [15:0]            lfsr = 16'd40;
  int                     cycle = 0;
  int                     n_err = 0;

  l1d_load_requester #(
    .N_LOAD_PORTS (N_LOAD_PORTS)
  ) dut0 (
    .i_clk          (clk),
    .i_reset_n      (reset_n),
    .i_load_req     (load_req),
    .o_load_resp    (load_resp),
    .i_stq_req      (stq_req),
    .o_stq_resp     (stq_resp),
    .o_l2_req       (l2_req),
    .i_l2_req_ready (l2_ready),
    .i_l2_resp      (l2_resp),
    .o_lrq_resolve  (resolve)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("Timeout: queue did not drain within %0d cycles", CYCLE_LIMIT);
      $display("Test FAILED");
      $finish;
    end
  end

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  // Twelve lines only, so that requests collide often
  function automatic logic [PADDR_W-1:0] pool_addr(input int k, input int off);
    logic [LINE_W-1:0] line;
    line = LINE_W'(32'h00a31c0 + k * 32'h0010203);
    return {line, LINE_OFF_W'(off)};
  endfunction

  function automatic string resp_name(input int r);
    return (r < N_LOAD_PORTS) ? $sformatf("o_load_resp[%0d]", r) : "o_stq_resp";
  endfunction

  task automatic drive_inputs(input logic stim);
    int due_i;
    for (int p = 0; p < N_LOAD_PORTS; p++) begin
      load_req[p].valid = stim && (rand_bits(1) != 0);
      load_req[p].paddr = pool_addr(rand_bits(4) % 12, rand_bits(6));
    end
    stq_req.valid = stim && (rand_bits(2) == 0);
    stq_req.paddr = pool_addr(rand_bits(4) % 12, rand_bits(6));
    // Long ready-low windows let the queue fill up
    if (!stim) begin
      l2_ready = 1'b1;
    end else if ((cycle % 700) >= 500) begin
      l2_ready = 1'b0;
    end else begin
      l2_ready = (rand_bits(2) != 0);
    end
    l2_resp = '0;
    due_i   = -1;
    for (int i = 0; i < pend_tag.size(); i++) begin
      if (due_i < 0 && pend_due[i] <= cycle) begin
        due_i = i;
      end
    end
    if (due_i >= 0) begin
      l2_resp.valid = 1'b1;
      l2_resp.tag   = pend_tag[due_i];
      pend_tag.delete(due_i);
      pend_due.delete(due_i);
    end else if (stim && rand_bits(4) == 0) begin
      // Fill for another source
      l2_resp.valid = 1'b1;
      l2_resp.tag   = {~L2_SRC_L1D, (L2_TAG_W-1)'(rand_bits(3))};
    end
  endtask

  task automatic check_and_step();
    lrq_req_t               req [N_REQ];
    lrq_resp_t              exp_resp [N_REQ];
    lrq_resp_t              got [N_REQ];
    int                     grant [N_REQ];
    logic [LRQ_ENTRIES-1:0] taken;
    logic [LINE_W-1:0]      line_r;
    l2_req_t                exp_l2;
    int                     pick;
    int                     idx;
    for (int p = 0; p < N_LOAD_PORTS; p++) begin
      req[p] = load_req[p];
      got[p] = load_resp[p];
    end
    req[N_REQ-1] = stq_req;
    got[N_REQ-1] = stq_resp;
    taken = '0;
    for (int r = 0; r < N_REQ; r++) begin
      exp_resp[r] = '0;
      grant[r]    = -1;
      line_r      = req[r].paddr[PADDR_W-1:LINE_OFF_W];
      if (req[r].valid) begin
        for (int e = 0; e < LRQ_ENTRIES; e++) begin
          if (m_valid[e] && m_line[e] == line_r) begin
            exp_resp[r].conflict    = 1'b1;
            exp_resp[r].index_oh[e] = 1'b1;
          end
        end
        for (int q = 0; q < r; q++) begin
          if (req[q].valid && req[q].paddr[PADDR_W-1:LINE_OFF_W] == line_r) begin
            exp_resp[r].conflict = 1'b1;
          end
        end
        if (!exp_resp[r].conflict) begin
          for (int e = LRQ_ENTRIES - 1; e >= 0; e--) begin
            if (!m_valid[e] && !taken[e]) begin
              grant[r] = e;
            end
          end
          if (grant[r] < 0) begin
            exp_resp[r].full = 1'b1;
          end else begin
            taken[grant[r]] = 1'b1;
          end
        end
      end
      if (got[r] !== exp_resp[r]) begin
        $display("[ERROR] %s expected %h got %h", resp_name(r), exp_resp[r], got[r]);
        n_err++;
      end
    end

    // Lowest unsent entry, unless a stalled command is still held
    pick = -1;
    for (int e = LRQ_ENTRIES - 1; e >= 0; e--) begin
      if (m_valid[e] && !m_sent[e]) begin
        pick = e;
      end
    end
    if (m_hold) begin
      pick = m_hold_idx;
    end
    exp_l2 = '0;
    if (pick >= 0) begin
      exp_l2.valid = 1'b1;
      exp_l2.cmd   = L2_CMD_RD;
      exp_l2.addr  = {m_line[pick], {LINE_OFF_W{1'b0}}};
      exp_l2.tag   = {L2_SRC_L1D, 1'b0, LRQ_IDX_W'(pick)};
    end
    if ((pick < 0 && l2_req.valid !== 1'b0) || (pick >= 0 && l2_req !== exp_l2)) begin
      $display("[ERROR] o_l2_req expected %h got %h", exp_l2, l2_req);
      n_err++;
    end
    if (resolve !== m_resolve) begin
      $display("[ERROR] o_lrq_resolve expected %h got %h", m_resolve, resolve);
      n_err++;
    end

    m_resolve = '0;
    if (l2_resp.valid && l2_resp.tag[L2_TAG_W-1] == L2_SRC_L1D) begin
      idx = int'(l2_resp.tag[LRQ_IDX_W-1:0]);
      m_resolve.valid                 = 1'b1;
      m_resolve.resolve_index_oh[idx] = 1'b1;
      m_valid[idx] = 1'b0;
      m_sent[idx]  = 1'b0;
    end
    if (pick >= 0 && l2_ready) begin
      m_sent[pick] = 1'b1;
      pend_tag.push_back(exp_l2.tag);
      pend_due.push_back(cycle + 1 + rand_bits(3) % 7);
    end
    m_hold     = (pick >= 0) && !l2_ready;
    m_hold_idx = pick;
    for (int r = 0; r < N_REQ; r++) begin
      if (grant[r] >= 0) begin
        m_valid[grant[r]] = 1'b1;
        m_sent[grant[r]]  = 1'b0;
        m_line[grant[r]]  = req[r].paddr[PADDR_W-1:LINE_OFF_W];
      end
    end
  endtask

  initial begin
    reset_n    = 1'b1;
    load_req   = '0;
    stq_req    = '0;
    l2_ready   = 1'b0;
    l2_resp    = '0;
    m_valid    = '0;
    m_sent     = '0;
    m_hold     = 1'b0;
    m_hold_idx = 0;
    m_resolve  = '0;
    repeat (10) @(negedge clk);
    reset_n = 1'b0;
    for (int c = 0; c < STIM_CYCLES; c++) begin
      drive_inputs(c >= 4);
      #10;
      check_and_step();
      @(negedge clk);
    end
    while (m_valid != '0 || pend_tag.size() != 0 || m_resolve.valid) begin
      drive_inputs(1'b0);
      #10;
      check_and_step();
      @(negedge clk);
    end
    $display("Errors: %0d, assertion failures: %0d", n_err, dut0.u_chk.n_fail);
    if (n_err == 0 && dut0.u_chk.n_fail == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* l1d_load_requester.f */
logic/lrq_pkg.sv
logic/lrq_entry.sv
logic/lrq_alloc.sv
logic/lrq_l2_issue.sv
logic/l1d_load_requester.sv
tb/l1d_load_requester_chk.sv
tb/tb_l1d_load_requester.sv
